/* src/spi_frame_pkg.sv */
`default_nettype none

// shared by every block that carries a transmit or receive word.
package spi_frame_pkg;

    // bits per SPI frame.
    localparam int WORD_W = 16;

    // one word on the data path, MSB is sent first.
    typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

/* src/spi_timing_pkg.sv */
`default_nettype none

// definitions for the sequencing of one SPI frame.
package spi_timing_pkg;

    // wide enough to index every bit of a frame.
    localparam int BIT_CNT_W = $clog2(spi_frame_pkg::WORD_W);

    // setup and hold each last CLK_DIV cycles around the shift phase.
    // DONE waits for the frame-start level to drop.
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        SHIFT,
        HOLD,
        DONE
    } engine_state_t;

endpackage

`default_nettype wire

/* src/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en,
    input  wire spi_frame_pkg::word_t   wr_data,
    input  wire                         rd_en,
    output spi_frame_pkg::word_t        rd_data,
    output logic                        full,
    output logic                        empty
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    spi_frame_pkg::word_t mem [FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              do_wr;
    logic              do_rd;

    // a write that arrives while full is lost.
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == (ADDR_W+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // the popped word shows up the cycle after rd_en.
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    ) else $error("word_fifo read while empty.");

    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst) count <= (ADDR_W+1)'(FIFO_DEPTH)
    ) else $error("word_fifo occupancy above depth.");

endmodule

`default_nettype wire

/* src/frame_launcher.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_launcher (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         empty,
    input  wire spi_frame_pkg::word_t   rd_data,
    input  wire                         fd,
    input  wire spi_frame_pkg::word_t   rxd,
    output logic                        rd_en,
    output logic                        fs,
    output spi_frame_pkg::word_t        txd,
    output logic                        rx_valid,
    output spi_frame_pkg::word_t        rx_data,
    output logic                        busy
);

    localparam logic [2:0] L_IDLE    = 3'd0;
    localparam logic [2:0] L_POP     = 3'd1;
    localparam logic [2:0] L_LOAD    = 3'd2;
    localparam logic [2:0] L_WAIT    = 3'd3;
    localparam logic [2:0] L_RELEASE = 3'd4;

    logic [2:0] state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= L_IDLE;
        end else begin
            case (state)
                L_IDLE:    if (!empty) state <= L_POP;
                L_POP:     state <= L_LOAD;
                L_LOAD:    state <= L_WAIT;
                L_WAIT:    if (fd) state <= L_RELEASE;
                L_RELEASE: state <= L_IDLE;
                default:   state <= L_IDLE;
            endcase
        end
    end

    // outputs decode straight from the state register.
    assign rd_en    = (state == L_POP);
    assign fs       = (state == L_WAIT);
    assign rx_valid = (state == L_RELEASE);
    assign busy     = (state != L_IDLE);

    always_ff @(posedge clk) begin
        if (state == L_LOAD) begin
            txd <= rd_data;
        end
        if (state == L_WAIT && fd) begin
            rx_data <= rxd;
        end
    end

    a_txd_stable: assert property (
        @(posedge clk) disable iff (rst) fs |=> !fs || $stable(txd)
    ) else $error("txd changed during a frame.");

endmodule

`default_nettype wire

/* src/spi_frame_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_engine #(
    parameter int CLK_DIV = 4
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         fs,
    input  wire spi_frame_pkg::word_t   txd,
    input  wire                         din,
    output logic                        fd,
    output logic                        cs,
    output logic                        sclk,
    output logic                        dout,
    output spi_frame_pkg::word_t        rxd
);

    localparam int W     = spi_frame_pkg::WORD_W;
    localparam int BW    = spi_timing_pkg::BIT_CNT_W;
    localparam int DIV_W = $clog2(2 * CLK_DIV);

    localparam logic [DIV_W-1:0] HALF_LAST   = DIV_W'(CLK_DIV - 1);
    localparam logic [DIV_W-1:0] PERIOD_LAST = DIV_W'(2 * CLK_DIV - 1);
    localparam logic [BW-1:0]    BIT_LAST    = BW'(W - 1);

    spi_timing_pkg::engine_state_t state;

    logic [DIV_W-1:0]     div_cnt;
    logic [BW-1:0]        bit_cnt;
    spi_frame_pkg::word_t tx_shift;
    spi_frame_pkg::word_t rx_shift;
    logic                 half_done;
    logic                 period_done;

    // half_done marks the end of setup, of hold, and of the low half of a bit.
    assign half_done   = (div_cnt == HALF_LAST);
    assign period_done = (div_cnt == PERIOD_LAST);

    assign dout = tx_shift[W-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= spi_timing_pkg::IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tx_shift <= '0;
            cs       <= 1'b1;
            sclk     <= 1'b0;
            fd       <= 1'b0;
        end else begin
            fd <= 1'b0;
            case (state)
                spi_timing_pkg::IDLE: begin
                    if (fs) begin
                        state    <= spi_timing_pkg::SETUP;
                        cs       <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        tx_shift <= txd;
                    end
                end
                spi_timing_pkg::SETUP: begin
                    if (half_done) begin
                        state   <= spi_timing_pkg::SHIFT;
                        div_cnt <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                spi_timing_pkg::SHIFT: begin
                    if (period_done) begin
                        // falling edge. the next bit goes out while sclk is low.
                        sclk    <= 1'b0;
                        div_cnt <= '0;
                        if (bit_cnt == BIT_LAST) begin
                            state <= spi_timing_pkg::HOLD;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            tx_shift <= {tx_shift[W-2:0], 1'b0};
                        end
                    end else begin
                        if (half_done) begin
                            sclk <= 1'b1;
                        end
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                spi_timing_pkg::HOLD: begin
                    if (half_done) begin
                        state    <= spi_timing_pkg::DONE;
                        cs       <= 1'b1;
                        fd       <= 1'b1;
                        tx_shift <= '0;
                        div_cnt  <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                spi_timing_pkg::DONE: begin
                    // a new frame needs fs to drop first.
                    if (!fs) begin
                        state <= spi_timing_pkg::IDLE;
                    end
                end
                default: begin
                    state <= spi_timing_pkg::IDLE;
                end
            endcase
        end
    end

    // din is taken on the same clock edge that raises sclk.
    always_ff @(posedge clk) begin
        if (state == spi_timing_pkg::SHIFT && half_done) begin
            rx_shift <= {rx_shift[W-2:0], din};
        end
        if (state == spi_timing_pkg::HOLD && half_done) begin
            rxd <= rx_shift;
        end
    end

    a_sclk_idle_low: assert property (
        @(posedge clk) disable iff (rst) cs |-> !sclk
    ) else $error("sclk high with chip select released.");

    a_fd_single: assert property (
        @(posedge clk) disable iff (rst) fd |=> !fd
    ) else $error("frame done held for more than one cycle.");

endmodule

`default_nettype wire

/* src/spi_link.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_link #(
    parameter int CLK_DIV    = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en,
    input  wire spi_frame_pkg::word_t   wr_data,
    input  wire                         din,
    output logic                        full,
    output logic                        rx_valid,
    output spi_frame_pkg::word_t        rx_data,
    output logic                        busy,
    output logic                        cs,
    output logic                        sclk,
    output logic                        dout
);

    logic                 empty;
    logic                 rd_en;
    logic                 fs;
    logic                 fd;
    spi_frame_pkg::word_t rd_data;
    spi_frame_pkg::word_t txd;
    spi_frame_pkg::word_t rxd;

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_word_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (full),
        .empty   (empty)
    );

    frame_launcher u_frame_launcher (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .rd_data  (rd_data),
        .fd       (fd),
        .rxd      (rxd),
        .rd_en    (rd_en),
        .fs       (fs),
        .txd      (txd),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .busy     (busy)
    );

    spi_frame_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_spi_frame_engine (
        .clk  (clk),
        .rst  (rst),
        .fs   (fs),
        .txd  (txd),
        .din  (din),
        .fd   (fd),
        .cs   (cs),
        .sclk (sclk),
        .dout (dout),
        .rxd  (rxd)
    );

endmodule

`default_nettype wire

/* test/spi_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

// mode 0 slave that answers each frame with the word it received in the frame before.
module spi_slave_model #(
    parameter spi_frame_pkg::word_t FIRST_REPLY = 16'hA5C3
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cs,
    input  wire                     sclk,
    input  wire                     dout,
    output logic                    din,
    output spi_frame_pkg::word_t    rx_word,
    output logic                    frame_done
);

    localparam int W = spi_frame_pkg::WORD_W;

    logic                 sclk_q;
    logic                 cs_q;
    spi_frame_pkg::word_t tx_shift;
    spi_frame_pkg::word_t rx_shift;

    // the pins are oversampled by the system clock, so every edge is seen one cycle late.
    assign din = tx_shift[W-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_q     <= 1'b0;
            cs_q       <= 1'b1;
            tx_shift   <= FIRST_REPLY;
            rx_shift   <= '0;
            rx_word    <= '0;
            frame_done <= 1'b0;
        end else begin
            sclk_q     <= sclk;
            cs_q       <= cs;
            frame_done <= 1'b0;
            if (!cs && sclk && !sclk_q) begin
                rx_shift <= {rx_shift[W-2:0], dout};
            end
            if (!cs && !sclk && sclk_q) begin
                tx_shift <= {tx_shift[W-2:0], 1'b0};
            end
            // release of chip select closes the frame and arms the echo.
            if (cs && !cs_q) begin
                rx_word    <= rx_shift;
                tx_shift   <= rx_shift;
                frame_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* test/spi_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_link_tb;

    localparam int CLK_DIV      = 4;
    localparam int FIFO_DEPTH   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int N_ENTRIES    = 23;
    localparam logic [31:0] SEED = 32'hff93_4b78;
    localparam spi_frame_pkg::word_t FIRST_REPLY = 16'hA5C3;

    // idle cycles before each write. entries 6 to 10 are written back to back,
    // and entries 11 to 22 are the FIFO_DEPTH + 4 overflow burst.
    localparam int GAPS [N_ENTRIES] = '{
        5, 150, 150, 150, 150, 150,
        150, 0, 0, 0, 0,
        750, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0
    };

    function automatic int gap_total();
        int sum;
        int k;
        sum = 0;
        for (k = 0; k < N_ENTRIES; k++) begin
            sum = sum + GAPS[k];
        end
        return sum;
    endfunction

    localparam int TIMEOUT_CYCLES =
        N_ENTRIES * (CLK_DIV * 34 + 10) + gap_total() + RESET_CYCLES + 500;

    logic                 clk;
    logic                 rst;
    logic                 wr_en;
    spi_frame_pkg::word_t wr_data;
    logic                 din;
    logic                 full;
    logic                 rx_valid;
    spi_frame_pkg::word_t rx_data;
    logic                 busy;
    logic                 cs;
    logic                 sclk;
    logic                 dout;
    spi_frame_pkg::word_t slave_word;
    logic                 slave_frame_done;

    spi_frame_pkg::word_t stim_word [N_ENTRIES];
    spi_frame_pkg::word_t accepted_words [$];
    logic saw_full    = 1'b0;
    logic sclk_prev   = 1'b0;
    logic cs_prev     = 1'b1;
    int   rx_count    = 0;
    int   slave_count = 0;
    int   frame_count = 0;
    int   sclk_rises  = 0;
    int   cycles      = 0;

    spi_link #(
        .CLK_DIV    (CLK_DIV),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_spi_link (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .din      (din),
        .full     (full),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .busy     (busy),
        .cs       (cs),
        .sclk     (sclk),
        .dout     (dout)
    );

    spi_slave_model #(
        .FIRST_REPLY (FIRST_REPLY)
    ) u_spi_slave_model (
        .clk        (clk),
        .rst        (rst),
        .cs         (cs),
        .sclk       (sclk),
        .dout       (dout),
        .din        (din),
        .rx_word    (slave_word),
        .frame_done (slave_frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, want);
            $display("=== FAIL ===");
            $fatal(1, "check failed");
        end
    endtask

    task automatic stop_run(input string why);
        $display("Run stopped at %0t ns: %s", $time, why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic build_table();
        int k;
        for (k = 0; k < N_ENTRIES; k++) begin
            stim_word[k] = 16'($urandom);
        end
        stim_word[0]  = 16'h0000;
        stim_word[1]  = 16'hFFFF;
        stim_word[2]  = 16'h8001;
        stim_word[3]  = 16'h1234;
        stim_word[7]  = 16'hFFFF;
        stim_word[12] = 16'h8001;
    endtask

    task automatic idle_cycles(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            wr_en = 1'b0;
        end
    endtask

    // a write made while full is high is dropped by the FIFO and expects no frame.
    task automatic write_word(input spi_frame_pkg::word_t w);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_data = w;
        if (full) begin
            saw_full = 1'b1;
        end else begin
            accepted_words.push_back(w);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_run("the run did not finish within the cycle limit.");
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (!cs && sclk && !sclk_prev) begin
                sclk_rises = sclk_rises + 1;
            end
            if (cs && !cs_prev) begin
                check(sclk_rises, 32'd16, "sclk rising edges in one frame");
                sclk_rises  = 0;
                frame_count = frame_count + 1;
            end
            if (slave_frame_done) begin
                if (slave_count >= accepted_words.size()) begin
                    stop_run("the slave saw a frame that no accepted write asked for.");
                end else begin
                    check(32'(slave_word), 32'(accepted_words[slave_count]), "word at slave");
                    slave_count = slave_count + 1;
                end
            end
            if (rx_valid) begin
                // the strobe comes in the cycle after done, which still counts as busy.
                check(32'(busy), 32'd1, "busy with rx_valid");
                if (rx_count >= accepted_words.size()) begin
                    stop_run("rx_valid arrived with no frame outstanding.");
                end else if (rx_count == 0) begin
                    check(32'(rx_data), 32'(FIRST_REPLY), "first received word");
                    rx_count = rx_count + 1;
                end else begin
                    check(32'(rx_data), 32'(accepted_words[rx_count-1]), "received word");
                    rx_count = rx_count + 1;
                end
            end
            sclk_prev = sclk;
            cs_prev   = cs;
        end
    end

    initial begin
        int i;
        void'($urandom(SEED));
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_data = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check(32'(cs), 32'd1, "cs after reset");
        check(32'(sclk), 32'd0, "sclk after reset");
        check(32'(busy), 32'd0, "busy after reset");
        check(32'(rx_valid), 32'd0, "rx_valid after reset");
        check(32'(full), 32'd0, "full after reset");

        for (i = 0; i < N_ENTRIES; i++) begin
            idle_cycles(GAPS[i]);
            write_word(stim_word[i]);
        end
        idle_cycles(1);
        check(32'(saw_full), 32'd1, "full during the overflow burst");

        while (rx_count != accepted_words.size() || busy) begin
            @(negedge clk);
        end
        check(slave_count, accepted_words.size(), "frames seen by the slave");
        check(frame_count, accepted_words.size(), "frames closed by cs");

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* spi_link.f */
src/spi_frame_pkg.sv
src/spi_timing_pkg.sv
src/word_fifo.sv
src/frame_launcher.sv
src/spi_frame_engine.sv
src/spi_link.sv
test/spi_slave_model.sv
test/spi_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module spi_link_tb \
    --Mdir obj_dir \
    -o spi_link_sim \
    -f spi_link.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit $build_status
fi

./obj_dir/spi_link_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi

echo "simulation finished cleanly"
exit 0
